//--- sources.f
source/route_pkg.sv
source/node_memory.sv
source/battery_hcm_index.sv
source/find_my_best.sv
source/route_node_top.sv
tb/tb_route_node.sv

//--- tb/tb_route_node.sv
`default_nettype none
`timescale 1ns/1ns

module tb_route_node;

	localparam int mem_words = 1024; // covers byte addresses up to 16'h07FF
	localparam int timeout_cycles = 2000; // 13 runs of at most ~85 cycles plus reset
	localparam int top_index = route_pkg::hcm_length - 1;

	logic clock;
	logic nrst;
	logic start;
	route_pkg::battery_t battery;
	route_pkg::mem_write_t mem_write;
	route_pkg::q_fixed_t mybest;
	logic done;

	route_pkg::q_fixed_t q_vals [32]; // testbench copy of the q table
	route_pkg::q_fixed_t hcm_vals [route_pkg::hcm_length]; // copy of the hcm table
	logic [31:0] lfsr = 32'h6385_dd4c; // random source state
	int cycle = 0; // edges since time zero
	int failures = 0;

	// expectations staged by the stimulus and latched on the start edge
	int next_n = 0;
	route_pkg::q_fixed_t next_best = route_pkg::best_init;
	int edges_left = 0; // edges until done must rise
	logic expect_done = 1'b0;
	logic fresh = 1'b1; // out of reset with no run yet
	route_pkg::q_fixed_t held_best = route_pkg::best_init;

	route_node_top #(
		.mem_words(mem_words)
	) dut0 (
		.clock(clock),
		.nrst(nrst),
		.start(start),
		.battery(battery),
		.mem_write(mem_write),
		.mybest(mybest),
		.done(done)
	);

	initial begin
		clock = 1'b0;
		forever #10 clock = ~clock; // 20 ns period
	end

	// x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_next(logic [31:0] state);
		logic fb;
		fb = state[31] ^ state[21] ^ state[1] ^ state[0];
		return {state[30:0], fb};
	endfunction

	// one lfsr step per bit taken
	task automatic draw_bits(input int width, output logic [31:0] value);
		value = '0;
		for (int i = 0; i < width; i++) begin
			lfsr = lfsr_next(lfsr);
			value = {value[30:0], lfsr[0]};
		end
	endtask

	task automatic report_mismatch(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		failures++;
		$display("[FAIL] t=%0t %s expected %h got %h", $time, name, expected, actual);
		$display("TEST FAILED");
		$fatal(1, "value mismatch on %s", name);
	endtask

	// reference model with min over q, ceil(10 x level) clamped and 11.5 scaling
	function automatic route_pkg::q_fixed_t expected_best(int n, route_pkg::battery_t level);
		route_pkg::q_fixed_t least;
		int tenfold;
		int k;
		logic [31:0] product;
		least = route_pkg::best_init;
		for (int i = 0; i < n; i++) begin
			if (q_vals[i] < least)
				least = q_vals[i];
		end
		tenfold = int'(level) * 10; // 1.15 times ten
		k = tenfold / 32768;
		if (tenfold % 32768 != 0)
			k++; // any fraction rounds up
		if (k > top_index)
			k = top_index;
		product = 32'(least) * 32'(hcm_vals[k]);
		return product[20:5];
	endfunction

	task automatic tick;
		@(posedge clock);
		#2; // drive point after the edge
	endtask

	task automatic write_word(input route_pkg::word_t addr, input route_pkg::word_t data);
		mem_write = '{en: 1'b1, addr: addr, data: data};
		tick();
	endtask

	task automatic load_tables(input int n);
		write_word(route_pkg::neighbor_count_addr, route_pkg::word_t'(n));
		for (int i = 0; i < n; i++)
			write_word(route_pkg::q_table_addr + route_pkg::word_t'(2 * i), q_vals[i]);
		for (int i = 0; i < route_pkg::hcm_length; i++)
			write_word(route_pkg::hcm_table_addr + route_pkg::word_t'(2 * i), hcm_vals[i]);
		mem_write = '0;
	endtask

	// integer part i+1 keeps every entry distinct
	task automatic fill_hcm;
		logic [31:0] frac;
		for (int i = 0; i < route_pkg::hcm_length; i++) begin
			draw_bits(5, frac);
			hcm_vals[i] = route_pkg::q_fixed_t'(((i + 1) << 5) | frac[4:0]);
		end
	endtask

	task automatic fill_random_q(input int n);
		logic [31:0] value;
		for (int i = 0; i < n; i++) begin
			draw_bits(16, value);
			q_vals[i] = value[15:0];
		end
	endtask

	task automatic fill_saturated_q(input int n);
		logic [31:0] value;
		for (int i = 0; i < n; i++) begin
			draw_bits(1, value);
			q_vals[i] = value[0] ? 16'hFFFF : 16'hFFFE; // never below the seed
		end
	endtask

	// load, start, wait for done, then hold a few edges with start low
	task automatic run_case(input int n, input route_pkg::battery_t level);
		battery = level;
		load_tables(n);
		next_n = n;
		next_best = expected_best(n, level);
		start = 1'b1;
		tick();
		start = 1'b0;
		while (!done)
			tick(); // watchdog bounds this
		repeat (3) tick();
	endtask

	// expected timing model registered like the dut
	always @(posedge clock) begin
		cycle <= cycle + 1;
		if (!nrst) begin
			edges_left <= 0;
			expect_done <= 1'b0;
			fresh <= 1'b1;
		end else if (start) begin // edge 0 of a run
			edges_left <= next_n + 5;
			expect_done <= 1'b0;
			fresh <= 1'b0;
			held_best <= next_best;
		end else begin
			if (edges_left == 1)
				expect_done <= 1'b1; // done rises on edge n+5
			if (edges_left != 0)
				edges_left <= edges_left - 1;
		end
	end

	done_timing: assert property (@(posedge clock) disable iff (!nrst) done == expect_done)
		else report_mismatch("done", 32'(expect_done), 32'($sampled(done)));

	result_value: assert property (@(posedge clock) disable iff (!nrst)
			expect_done |-> mybest == held_best)
		else report_mismatch("mybest", 32'(held_best), 32'($sampled(mybest)));

	reset_value: assert property (@(posedge clock) disable iff (!nrst)
			fresh |-> mybest == route_pkg::best_init)
		else report_mismatch("mybest", 32'(route_pkg::best_init), 32'($sampled(mybest)));

	initial begin
		while (cycle < timeout_cycles)
			@(posedge clock);
		$display("timeout after %0d cycles, done never came back", cycle);
		$display("TEST FAILED");
		$fatal(1, "watchdog expired");
	end

	initial begin
		logic [31:0] pick;
		logic [31:0] level;
		nrst = 1'b0;
		start = 1'b0;
		battery = '0;
		mem_write = '0;
		repeat (16) @(posedge clock);
		#2 nrst = 1'b1;
		fill_hcm();
		repeat (4) tick(); // idle after reset under the reset_value check

		// smallest and largest neighbor count
		fill_random_q(1);
		draw_bits(16, level);
		run_case(1, level[15:0]);
		fill_random_q(32);
		draw_bits(16, level);
		run_case(32, level[15:0]);

		// random counts and levels with each start while done is high
		for (int r = 0; r < 6; r++) begin
			draw_bits(5, pick);
			fill_random_q(int'(pick[4:0]) + 1);
			draw_bits(16, level);
			run_case(int'(pick[4:0]) + 1, level[15:0]);
		end

		// index corners at zero, exact 0.5, just above 0.5 and just above one
		fill_random_q(5);
		for (int i = 0; i < 5; i++)
			q_vals[i] = q_vals[i] | 16'h0020; // nothing below 1.0
		q_vals[3] = 16'h0020; // minimum of 1.0 passes the hcm entry through
		run_case(5, 16'h0000);
		run_case(5, 16'h4000); // index 5 without round-up
		run_case(5, 16'h4001); // rounds up to 6
		run_case(5, 16'h8001); // 11 clamps to 10

		// nothing below the seed so the minimum stays best_init
		fill_saturated_q(20);
		draw_bits(16, level);
		run_case(20, level[15:0]);

		if (failures == 0)
			$display("TEST PASSED");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

`default_nettype wire

//--- source/route_node_top.sv
`default_nettype none
`timescale 1ns/1ns

module route_node_top #(
	parameter int mem_words = 1024 // memory depth in words
) (
	input wire logic clock,
	input wire logic nrst,
	input wire logic start, // run request
	input wire route_pkg::battery_t battery, // node battery level
	input wire route_pkg::mem_write_t mem_write, // host load port
	output route_pkg::q_fixed_t mybest, // scaled best q-value
	output logic done // result valid
);

	route_pkg::word_t address; // finder read address
	route_pkg::word_t data_in; // memory read data
	logic index_go; // finder to index unit
	logic index_valid; // index unit to finder
	route_pkg::hcm_index_t hcm_index; // clamped hcm index

	node_memory #(
		.mem_words(mem_words)
	) mem0 (
		.clock(clock),
		.mem_write(mem_write),
		.address(address),
		.data_in(data_in)
	);

	battery_hcm_index index0 (
		.clock(clock),
		.nrst(nrst),
		.index_go(index_go),
		.battery(battery),
		.index_valid(index_valid),
		.hcm_index(hcm_index)
	);

	find_my_best finder0 (
		.clock(clock),
		.nrst(nrst),
		.start(start),
		.data_in(data_in),
		.index_valid(index_valid),
		.hcm_index(hcm_index),
		.address(address),
		.index_go(index_go),
		.mybest(mybest),
		.done(done)
	);

endmodule

`default_nettype wire

//--- source/find_my_best.sv
`default_nettype none
`timescale 1ns/1ns

module find_my_best (
	input wire logic clock,
	input wire logic nrst,
	input wire logic start, // run request
	input wire route_pkg::word_t data_in, // memory read data
	input wire logic index_valid, // hcm index ready
	input wire route_pkg::hcm_index_t hcm_index, // clamped table index
	output route_pkg::word_t address, // memory byte address
	output logic index_go, // kick the index unit
	output route_pkg::q_fixed_t mybest, // running then scaled minimum
	output logic done // result valid and held
);

	typedef enum logic [2:0] {
		idle,
		count, // neighbor count on data_in
		scan, // one q-value per cycle
		wait_index, // index unit busy
		scale, // hcm entry on data_in
		finished
	} state_t;

	state_t state; // control state

	route_pkg::word_t neighbor_count; // n latched once per run
	route_pkg::word_t last_addr; // address of q-value n-1
	route_pkg::word_t hcm_addr; // selected hcm entry
	logic [31:0] scaled; // 22.10 product
	logic last_q; // final compare this cycle
	logic run_req; // start accepted

	// q_table_addr + 2*(n-1)
	assign last_addr = route_pkg::q_table_addr + ((neighbor_count - 16'd1) << 1);

	assign hcm_addr = route_pkg::hcm_table_addr + {11'b0, hcm_index, 1'b0};

	// 11.5 x 11.5 product before the 11.5 window
	assign scaled = {16'b0, mybest} * {16'b0, data_in};

	assign last_q = (state == scan) && (address == last_addr);

	// index unit samples battery on the last compare edge
	assign index_go = last_q;

	// start only counts when not busy
	assign run_req = start && (state == idle || state == finished);

	always_ff @(posedge clock) begin
		if (!nrst) begin
			state <= idle;
			address <= route_pkg::neighbor_count_addr;
			mybest <= route_pkg::best_init;
			done <= 1'b0;
		end else begin
			if (run_req) begin // new run clears the result
				state <= count;
				address <= route_pkg::neighbor_count_addr;
				mybest <= route_pkg::best_init;
				done <= 1'b0;
			end else begin
				case (state)
					count: begin
						state <= scan;
						address <= route_pkg::q_table_addr; // first q-value
					end
					scan: begin
						if (data_in < mybest) // unsigned compare
							mybest <= data_in;
						if (last_q)
							state <= wait_index; // hold address
						else
							address <= address + 16'd2; // next neighbor
					end
					wait_index: begin
						if (index_valid) begin
							address <= hcm_addr; // hcm entry for the level
							state <= scale;
						end
					end
					scale: begin
						mybest <= scaled[20:5]; // drop low fraction
						done <= 1'b1;
						state <= finished;
					end
					default: ; // idle and finished wait for start
				endcase
			end
		end
	end

	// neighbor count word read in the count state
	always_ff @(posedge clock) begin
		if (state == count) begin
			neighbor_count <= data_in; // 1 .. 32 by contract
		end
	end

endmodule

`default_nettype wire

//--- source/battery_hcm_index.sv
`default_nettype none
`timescale 1ns/1ns

module battery_hcm_index (
	input wire logic clock,
	input wire logic nrst,
	input wire logic index_go, // one-cycle request
	input wire route_pkg::battery_t battery, // 1.15 level
	output logic index_valid, // one-cycle result strobe
	output route_pkg::hcm_index_t hcm_index // held until next request
);

	localparam int max_index = route_pkg::hcm_length - 1; // clamp ceiling

	logic [1:0] step; // 0 idle, 1 round, 2 clamp
	logic [31:0] product; // 17.15 product, later the rounded value
	route_pkg::word_t rounded; // ceil of product
	logic frac_nonzero; // any bit below the binary point

	assign frac_nonzero = |product[14:0];
	assign rounded = product[30:15] + {15'b0, frac_nonzero}; // round up

	// step sequencing
	always_ff @(posedge clock) begin
		if (!nrst) begin
			step <= 2'd0;
			index_valid <= 1'b0;
		end else begin
			index_valid <= (step == 2'd2); // pulse on clamp edge
			case (step)
				2'd0: if (index_go) step <= 2'd1; // sample battery now
				2'd1: step <= 2'd2;
				default: step <= 2'd0; // clamp done
			endcase
		end
	end

	// datapath
	always_ff @(posedge clock) begin
		if (step == 2'd0 && index_go) begin
			product <= {16'b0, battery} * 32'd10; // 10 x level
		end else if (step == 2'd1) begin
			product <= {16'b0, rounded}; // reuse as integer holder
		end
	end

	always_ff @(posedge clock) begin
		if (step == 2'd2) begin
			if (product[15:0] > route_pkg::word_t'(max_index))
				hcm_index <= route_pkg::hcm_index_t'(max_index); // saturate
			else
				hcm_index <= product[3:0];
		end
	end

endmodule

`default_nettype wire

//--- source/node_memory.sv
`default_nettype none
`timescale 1ns/1ns

module node_memory #(
	parameter int mem_words = 1024 // depth in 16-bit words
) (
	input wire logic clock,
	input wire route_pkg::mem_write_t mem_write, // host side
	input wire route_pkg::word_t address, // finder byte address
	output route_pkg::word_t data_in // finder read data
);

	localparam int aw = (mem_words > 1) ? $clog2(mem_words) : 1; // word index width

	route_pkg::word_t mem [mem_words]; // contents, no reset

	logic [aw-1:0] wr_index; // host word index
	logic [aw-1:0] rd_index; // finder word index

	// byte address to word index, bit 0 dropped
	assign wr_index = aw'(mem_write.addr >> 1);
	assign rd_index = aw'(address >> 1);

	always_ff @(posedge clock) begin
		if (mem_write.en) begin // host store
			mem[wr_index] <= mem_write.data;
		end
	end

	// asynchronous read, finder samples on next edge
	assign data_in = mem[rd_index];

endmodule

`default_nettype wire

//--- source/route_pkg.sv
`default_nettype none

package route_pkg;

	parameter int word_width = 16; // data and byte address width

	typedef logic [word_width-1:0] word_t; // raw memory word
	typedef logic [word_width-1:0] q_fixed_t; // unsigned 11.5
	typedef logic [word_width-1:0] battery_t; // unsigned 1.15

	parameter int hcm_length = 11; // hop-cost multiplier entries

	typedef logic [3:0] hcm_index_t; // 0 .. hcm_length-1

	// byte addresses in node data memory
	parameter word_t neighbor_count_addr = 16'h068A; // single word
	parameter word_t q_table_addr = 16'h01C8; // q-values, step 2
	parameter word_t hcm_table_addr = 16'h0648; // hcm entries, step 2

	parameter q_fixed_t best_init = 16'hFFFE; // minimum search seed

	// host write port
	typedef struct packed {
		logic en; // write strobe
		word_t addr; // byte address, bit 0 ignored
		word_t data; // word to store
	} mem_write_t;

endpackage

`default_nettype wire
